/* Bender.yml */
package:
  name: cpu_core

sources:
  # Packages first, then RTL in dependency order
  - source/isa_pkg.sv
  - source/host_pkg.sv
  - source/control_logic.sv
  - source/apb_host_port.sv
  - source/instr_queue.sv
  - source/exec_unit.sv
  - source/cpu_core.sv

  - target: simulation
    files:
      - verification/cpu_core_tb.sv

/* source/apb_host_port.sv */
// APB host port
`timescale 1ns/1ns

module apb_host_port import isa_pkg::*, host_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	output logic      push,
	output word_t     push_data,
	input  logic      full,
	input  level_t    level,
	output reg_idx_t  reg_rd_idx,
	input  word_t     reg_rd_data,
	input  word_t     retired_count,
	input  logic      error_flag
);

	reg_idx_t reg_sel;
	logic     access;    // APB access phase
	logic     instr_wr;
	logic     map_err;
	logic     busy;

	assign access   = psel && penable;
	assign instr_wr = pwrite && (paddr == ADDR_INSTR);
	assign busy     = (level != '0);

	// Unmapped address or wrong direction
	always_comb begin
		case (paddr)
			ADDR_INSTR:    map_err = !pwrite;
			ADDR_STATUS:   map_err = pwrite;
			ADDR_REG_SEL:  map_err = 1'b0;
			ADDR_REG_DATA: map_err = pwrite;
			default:       map_err = 1'b1;
		endcase
	end

	assign pready     = access && !(instr_wr && full);  // Wait states only on a full queue
	assign pslverr    = pready && map_err;
	assign push       = access && instr_wr && !full;
	assign push_data  = pwdata[15:0];
	assign reg_rd_idx = reg_sel;

	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (paddr)
				ADDR_STATUS:   prdata = {retired_count, 10'd0, error_flag, busy, level};
				ADDR_REG_SEL:  prdata = {28'd0, reg_sel};
				ADDR_REG_DATA: prdata = {16'd0, reg_rd_data};
				default:       prdata = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_sel <= '0;
		end else if (pready && pwrite && (paddr == ADDR_REG_SEL)) begin
			reg_sel <= pwdata[3:0];
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) penable |-> psel)
		else $error("apb_host_port: penable without psel");

	// A stalled transfer must hold its address and direction
	assert property (@(posedge clk) disable iff (!arst_n)
		access && !pready |=> access && $stable(paddr) && $stable(pwrite))
		else $error("apb_host_port: transfer changed during wait state");

endmodule

/* source/control_logic.sv */
// Opcode decoder
`timescale 1ns/1ns

module control_logic import isa_pkg::*; (
	input  opcode_t opcode,
	output logic    data_reg,      // First read port takes the DS register
	output logic    mem_to_reg,
	output logic    alu_src,       // Immediate as second ALU operand
	output logic    sign_ext_sel,  // 0 -> 4 bit field, 1 -> imm8
	output logic    reg_rt_src,    // Second read port takes rd
	output logic    reg_write,
	output logic    mem_write,
	output logic    mem_read,
	output logic    load_half,     // Byte merge result
	output logic    half_spec,     // 0 -> LHB, 1 -> LLB
	output logic    illegal,
	output alu_op_t alu_op
);

	always_comb begin
		// Defaults write nothing
		data_reg     = 1'b0;
		mem_to_reg   = 1'b0;
		alu_src      = 1'b0;
		sign_ext_sel = 1'b0;
		reg_rt_src   = 1'b0;
		reg_write    = 1'b0;
		mem_write    = 1'b0;
		mem_read     = 1'b0;
		load_half    = 1'b0;
		half_spec    = 1'b0;
		illegal      = 1'b0;
		alu_op       = ALU_ADD;

		case (opcode)
			OP_ADD, OP_SUB, OP_NAND, OP_XOR, OP_SRA, OP_SRL, OP_SLL: begin
				alu_op    = alu_op_t'(opcode[2:0]);
				reg_write = 1'b1;
			end
			OP_INC: begin
				alu_op    = ALU_INC;
				alu_src   = 1'b1;  // Signed 4 bit field
				reg_write = 1'b1;
			end
			OP_LW: begin
				data_reg     = 1'b1;
				mem_to_reg   = 1'b1;
				alu_src      = 1'b1;
				sign_ext_sel = 1'b1;
				reg_write    = 1'b1;
				mem_read     = 1'b1;
			end
			OP_SW: begin
				data_reg     = 1'b1;
				alu_src      = 1'b1;
				sign_ext_sel = 1'b1;
				reg_rt_src   = 1'b1;  // Store data comes from rd
				mem_write    = 1'b1;
			end
			OP_LHB: begin
				reg_rt_src = 1'b1;
				reg_write  = 1'b1;
				load_half  = 1'b1;
			end
			OP_LLB: begin
				reg_rt_src = 1'b1;
				reg_write  = 1'b1;
				load_half  = 1'b1;
				half_spec  = 1'b1;
			end
			OP_B, OP_CALL, OP_RET, OP_ERR: begin
				illegal = 1'b1;
			end
			default: begin
				illegal = 1'b1;  // Unknown opcode bits
			end
		endcase
	end

	// Decode table never requests a load and a store together
	assert property (@(opcode) !$isunknown(opcode) |-> !(mem_write && mem_read))
		else $error("control_logic: mem_write and mem_read both set");

endmodule

/* source/cpu_core.sv */
// Load/store core top level
`timescale 1ns/1ns

module cpu_core import isa_pkg::*, host_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr
);

	// Host port to queue
	logic     push;
	word_t    push_data;
	logic     full;
	level_t   level;

	// Queue to execution unit
	logic     pop;
	word_t    pop_data;
	logic     empty;

	// Execution unit back to host port
	reg_idx_t reg_rd_idx;
	word_t    reg_rd_data;
	word_t    retired_count;
	logic     error_flag;

	apb_host_port apb_host_port_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.push          (push),
		.push_data     (push_data),
		.full          (full),
		.level         (level),
		.reg_rd_idx    (reg_rd_idx),
		.reg_rd_data   (reg_rd_data),
		.retired_count (retired_count),
		.error_flag    (error_flag)
	);

	instr_queue instr_queue_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_data (push_data),
		.full      (full),
		.level     (level),
		.pop       (pop),
		.pop_data  (pop_data),
		.empty     (empty)
	);

	exec_unit exec_unit_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.pop_data      (pop_data),
		.empty         (empty),
		.pop           (pop),
		.reg_rd_idx    (reg_rd_idx),
		.reg_rd_data   (reg_rd_data),
		.retired_count (retired_count),
		.error_flag    (error_flag)
	);

endmodule

/* source/exec_unit.sv */
// Instruction execution unit
`timescale 1ns/1ns

module exec_unit import isa_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  word_t    pop_data,
	input  logic     empty,
	output logic     pop,
	input  reg_idx_t reg_rd_idx,
	output word_t    reg_rd_data,
	output word_t    retired_count,
	output logic     error_flag
);

	word_t regs [NUM_REGS];
	word_t dmem [DMEM_WORDS];

	logic       data_reg, mem_to_reg, alu_src, sign_ext_sel, reg_rt_src;
	logic       reg_write, mem_write, mem_read, load_half, half_spec, illegal;
	alu_op_t    alu_op;
	opcode_t    opcode;
	reg_idx_t   rd, rs, rt;
	reg_idx_t   idx_a, idx_b;
	logic [7:0] imm8;
	word_t      op_a, op_b, imm_ext, alu_b, alu_res;
	word_t      mem_rd, half_res, wb_data;
	dmem_addr_t mem_addr;

	// Instruction fields
	assign opcode = pop_data[15:12];
	assign rd     = pop_data[11:8];
	assign rs     = pop_data[7:4];
	assign rt     = pop_data[3:0];
	assign imm8   = pop_data[7:0];

	control_logic control_logic_inst (
		.opcode       (opcode),
		.data_reg     (data_reg),
		.mem_to_reg   (mem_to_reg),
		.alu_src      (alu_src),
		.sign_ext_sel (sign_ext_sel),
		.reg_rt_src   (reg_rt_src),
		.reg_write    (reg_write),
		.mem_write    (mem_write),
		.mem_read     (mem_read),
		.load_half    (load_half),
		.half_spec    (half_spec),
		.illegal      (illegal),
		.alu_op       (alu_op)
	);

	assign pop = !empty;  // One instruction per cycle

	// Register file read ports, register 0 is never written
	assign idx_a       = data_reg ? DS_REG : rs;
	assign idx_b       = reg_rt_src ? rd : rt;
	assign op_a        = regs[idx_a];
	assign op_b        = regs[idx_b];
	assign reg_rd_data = regs[reg_rd_idx];  // Host read port

	assign imm_ext = sign_ext_sel ? {{8{imm8[7]}}, imm8} : {{12{rt[3]}}, rt};
	assign alu_b   = alu_src ? imm_ext : op_b;

	always_comb begin
		unique case (alu_op)
			ALU_ADD:  alu_res = op_a + alu_b;
			ALU_SUB:  alu_res = op_a - alu_b;
			ALU_NAND: alu_res = ~(op_a & alu_b);
			ALU_XOR:  alu_res = op_a ^ alu_b;
			ALU_INC:  alu_res = op_a + alu_b;
			ALU_SRA:  alu_res = $signed(op_a) >>> alu_b[3:0];
			ALU_SRL:  alu_res = op_a >> alu_b[3:0];
			ALU_SLL:  alu_res = op_a << alu_b[3:0];
		endcase
	end

	assign mem_addr = alu_res[7:0];  // DS plus offset, low byte
	assign mem_rd   = mem_read ? dmem[mem_addr] : '0;
	assign half_res = half_spec ? {op_b[15:8], imm8} : {imm8, op_b[7:0]};
	assign wb_data  = load_half ? half_res : (mem_to_reg ? mem_rd : alu_res);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (pop && reg_write && (rd != '0)) begin
			regs[rd] <= wb_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (pop && mem_write) begin
			dmem[mem_addr] <= op_b;
		end
	end

	// Retire counter and sticky error
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retired_count <= '0;
			error_flag    <= 1'b0;
		end else if (pop) begin
			retired_count <= retired_count + 1'b1;
			if (illegal) begin
				error_flag <= 1'b1;
			end
		end
	end

	// Show-ahead queue must present a valid word whenever it is popped
	assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> !empty && !$isunknown(pop_data))
		else $error("exec_unit: pop without a valid head word");

endmodule

/* source/host_pkg.sv */
// Host interface definitions

package host_pkg;

	typedef logic [3:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Register map
	localparam apb_addr_t ADDR_INSTR    = 4'h0;  // Write only, pushes PWDATA[15:0]
	localparam apb_addr_t ADDR_STATUS   = 4'h4;  // Read only
	localparam apb_addr_t ADDR_REG_SEL  = 4'h8;
	localparam apb_addr_t ADDR_REG_DATA = 4'hC;  // Read only

	// Instruction queue sizing
	localparam int QUEUE_DEPTH = 8;

	typedef logic [3:0] level_t;  // Holds 0 up to QUEUE_DEPTH
	typedef logic [$clog2(QUEUE_DEPTH)-1:0] qptr_t;

endpackage

/* source/instr_queue.sv */
// Instruction FIFO
`timescale 1ns/1ns

module instr_queue import isa_pkg::*, host_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   push,
	input  word_t  push_data,
	output logic   full,
	output level_t level,
	input  logic   pop,
	output word_t  pop_data,
	output logic   empty
);

	word_t mem [QUEUE_DEPTH];
	qptr_t wr_ptr;
	qptr_t rd_ptr;

	assign full     = (level == level_t'(QUEUE_DEPTH));
	assign empty    = (level == '0);
	assign pop_data = mem[rd_ptr];  // Show-ahead head word

	// Storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap on their own for a power of two depth
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;  // Idle or push and pop together
			endcase
		end
	end

	// Host port must stall pushes while full
	assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
		else $error("instr_queue: push while full");

	assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
		else $error("instr_queue: pop while empty");

endmodule

/* source/isa_pkg.sv */
// Instruction set definitions

package isa_pkg;

	typedef logic [3:0]  opcode_t;   // Word bits 15..12
	typedef logic [3:0]  reg_idx_t;
	typedef logic [15:0] word_t;     // Data and instruction word

	// ALU group, low three bits double as the ALU select
	localparam opcode_t OP_ADD  = 4'b0000;
	localparam opcode_t OP_SUB  = 4'b0001;
	localparam opcode_t OP_NAND = 4'b0010;
	localparam opcode_t OP_XOR  = 4'b0011;
	localparam opcode_t OP_INC  = 4'b0100;
	localparam opcode_t OP_SRA  = 4'b0101;
	localparam opcode_t OP_SRL  = 4'b0110;
	localparam opcode_t OP_SLL  = 4'b0111;

	// Memory and byte loads
	localparam opcode_t OP_LW   = 4'b1000;
	localparam opcode_t OP_SW   = 4'b1001;
	localparam opcode_t OP_LHB  = 4'b1010;
	localparam opcode_t OP_LLB  = 4'b1011;

	// Flow control needs a program counter, so these decode as illegal
	localparam opcode_t OP_B    = 4'b1100;
	localparam opcode_t OP_CALL = 4'b1101;
	localparam opcode_t OP_RET  = 4'b1110;
	localparam opcode_t OP_ERR  = 4'b1111;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'b000,
		ALU_SUB  = 3'b001,
		ALU_NAND = 3'b010,
		ALU_XOR  = 3'b011,
		ALU_INC  = 3'b100,
		ALU_SRA  = 3'b101,
		ALU_SRL  = 3'b110,
		ALU_SLL  = 3'b111
	} alu_op_t;

	localparam int       NUM_REGS   = 16;
	localparam reg_idx_t DS_REG     = 4'd14;  // Data segment base
	localparam int       DMEM_WORDS = 256;
	typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_addr_t;

endpackage

/* sources.f */
source/isa_pkg.sv
source/host_pkg.sv
source/control_logic.sv
source/apb_host_port.sv
source/instr_queue.sv
source/exec_unit.sv
source/cpu_core.sv
verification/cpu_core_tb.sv

/* verification/cpu_core_tb.sv */
// Load/store core testbench
`timescale 1ns/1ns

module cpu_core_tb import isa_pkg::*, host_pkg::*; ();

	localparam int HALF_PERIOD = 4;
	localparam int WAIT_LIMIT  = 64;   // Cycles or polls per wait
	localparam int NUM_CASES   = 19;
	localparam int NUM_RANDOM  = 16;

	typedef struct packed {
		opcode_t  op;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;    // Also the INC immediate or low nibble of imm8
		word_t    a;     // Loaded into rs
		word_t    b;     // Loaded into rt
		word_t    exp;
	} alu_case_t;

	logic      clk;
	logic      arst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;

	integer      seed;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          errors_before;
	apb_data_t   rdata;
	logic        err;
	word_t       value;
	word_t       count_before;
	logic [31:0] rnd;
	alu_case_t   rand_case;
	alu_case_t   alu_table [NUM_CASES];

	cpu_core cpu_core_inst (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #HALF_PERIOD clk = ~clk;

	// One APB transfer, setup then access, outputs sampled mid low phase
	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rd_data, output logic rd_err);
		int waits;
		waits = 0;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#2;
		while (!pready && waits < WAIT_LIMIT) begin
			@(negedge clk);
			#2;
			waits++;
		end
		if (!pready) begin
			$display("timeout at %0t: no pready for address %h", $time, addr);
			$display("TEST FAIL");
			$finish;
		end else begin
			rd_data = prdata;
			rd_err  = pslverr;
			@(negedge clk);  // Transfer ends on the rising edge before this
			psel    = 1'b0;
			penable = 1'b0;
		end
	endtask

	task automatic push_instr(input word_t instr);
		apb_data_t d;
		logic      e;
		apb_xfer(1'b1, ADDR_INSTR, {16'd0, instr}, d, e);
	endtask

	task automatic load_reg(input reg_idx_t idx, input word_t val);
		push_instr({OP_LLB, idx, val[7:0]});
		push_instr({OP_LHB, idx, val[15:8]});
	endtask

	// Poll STATUS until the queue level reads zero
	task automatic drain_queue();
		apb_data_t status;
		logic      e;
		int        polls;
		polls = 0;
		apb_xfer(1'b0, ADDR_STATUS, '0, status, e);
		while (status[3:0] != 4'd0 && polls < WAIT_LIMIT) begin
			apb_xfer(1'b0, ADDR_STATUS, '0, status, e);
			polls++;
		end
		if (status[3:0] != 4'd0) begin
			$display("timeout at %0t: instruction queue never drained", $time);
			$display("TEST FAIL");
			$finish;
		end
	endtask

	task automatic read_reg(input reg_idx_t idx, output word_t val);
		apb_data_t d;
		logic      e;
		apb_xfer(1'b1, ADDR_REG_SEL, {28'd0, idx}, d, e);
		apb_xfer(1'b0, ADDR_REG_DATA, '0, d, e);
		val = d[15:0];
	endtask

	task automatic compare_word(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors != errs_at_start) begin
			tests_failed++;
			$display("test %s failed", name);
		end else begin
			$display("test %s passed", name);
		end
	endtask

	// Expected ALU result from the instruction format rules
	function automatic word_t alu_model(input logic [2:0] op, input word_t a, input word_t b,
			input logic [3:0] imm);
		case (op)
			3'd0:    return a + b;
			3'd1:    return a - b;
			3'd2:    return ~(a & b);
			3'd3:    return a ^ b;
			3'd4:    return a + {{12{imm[3]}}, imm};
			3'd5:    return word_t'($signed(a) >>> b[3:0]);
			3'd6:    return a >> b[3:0];
			default: return a << b[3:0];
		endcase
	endfunction

	task automatic run_case(input alu_case_t c, input string name);
		word_t got;
		int    errs_at_start;
		errs_at_start = errors;
		load_reg(c.rs, c.a);
		if (c.op != OP_INC) begin
			load_reg(c.rt, c.b);  // For INC the rt field is the immediate
		end
		push_instr({c.op, c.rd, c.rs, c.rt});
		drain_queue();
		read_reg(c.rd, got);
		compare_word($sformatf("r%0d", c.rd), got, c.exp);
		report_test(name, errs_at_start);
	endtask

	initial begin
		seed         = 32'h5541e393;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		clk          = 1'b0;
		arst_n       = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;

		alu_table[0]  = {OP_ADD,  4'd5, 4'd1, 4'd2, 16'h1234, 16'h0F0F, 16'h2143};
		alu_table[1]  = {OP_ADD,  4'd5, 4'd1, 4'd2, 16'hFFFF, 16'h0002, 16'h0001};
		alu_table[2]  = {OP_SUB,  4'd5, 4'd1, 4'd2, 16'h1000, 16'h0001, 16'h0FFF};
		alu_table[3]  = {OP_SUB,  4'd5, 4'd1, 4'd2, 16'h0003, 16'h0005, 16'hFFFE};
		alu_table[4]  = {OP_NAND, 4'd5, 4'd1, 4'd2, 16'hF0F0, 16'hFF00, 16'h0FFF};
		alu_table[5]  = {OP_XOR,  4'd5, 4'd1, 4'd2, 16'hAAAA, 16'h0FF0, 16'hA55A};
		alu_table[6]  = {OP_INC,  4'd5, 4'd1, 4'd5, 16'h00FF, 16'h0000, 16'h0104};
		alu_table[7]  = {OP_INC,  4'd5, 4'd1, 4'hD, 16'h0010, 16'h0000, 16'h000D};  // -3
		alu_table[8]  = {OP_INC,  4'd5, 4'd1, 4'hF, 16'h0000, 16'h0000, 16'hFFFF};
		alu_table[9]  = {OP_SRA,  4'd5, 4'd1, 4'd2, 16'h8F00, 16'h0004, 16'hF8F0};
		alu_table[10] = {OP_SRA,  4'd5, 4'd1, 4'd2, 16'h8001, 16'h0000, 16'h8001};
		alu_table[11] = {OP_SRA,  4'd5, 4'd1, 4'd2, 16'h8000, 16'h000F, 16'hFFFF};
		alu_table[12] = {OP_SRL,  4'd5, 4'd1, 4'd2, 16'h8000, 16'h000F, 16'h0001};
		alu_table[13] = {OP_SRL,  4'd5, 4'd1, 4'd2, 16'h1234, 16'h0000, 16'h1234};
		alu_table[14] = {OP_SLL,  4'd5, 4'd1, 4'd2, 16'h0003, 16'h000F, 16'h8000};
		alu_table[15] = {OP_SLL,  4'd5, 4'd1, 4'd2, 16'h0123, 16'h0014, 16'h1230};
		alu_table[16] = {OP_LHB,  4'd3, 4'hC, 4'd3, 16'h0000, 16'h1234, 16'hC334};  // imm8 C3
		alu_table[17] = {OP_LLB,  4'd5, 4'h9, 4'd5, 16'h0000, 16'hABCD, 16'hAB95};  // imm8 95
		alu_table[18] = {OP_ADD,  4'd0, 4'd1, 4'd2, 16'h1111, 16'h2222, 16'h0000};

		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		errors_before = errors;
		apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
		compare_word("status", rdata, 32'd0);
		read_reg(4'd7, value);
		compare_word("r7", value, 16'd0);
		report_test("reset values", errors_before);

		for (int i = 0; i < NUM_CASES; i++) begin
			run_case(alu_table[i], $sformatf("table case %0d", i));
		end

		for (int i = 0; i < NUM_RANDOM; i++) begin
			rnd          = $random(seed);
			rand_case.op = {1'b0, rnd[2:0]};
			rand_case.rd = 4'd5;
			rand_case.rs = 4'd6;
			rand_case.rt = (rand_case.op == OP_INC) ? rnd[7:4] : 4'd7;
			rand_case.a  = rnd[31:16];
			rnd          = $random(seed);
			rand_case.b  = rnd[15:0];
			rand_case.exp = alu_model(rand_case.op[2:0], rand_case.a, rand_case.b, rand_case.rt);
			run_case(rand_case, $sformatf("random case %0d", i));
		end

		// Store and load through DS with positive and negative offsets
		errors_before = errors;
		load_reg(DS_REG, 16'h0040);
		load_reg(4'd3, 16'hBEEF);
		load_reg(4'd4, 16'h1357);
		push_instr({OP_SW, 4'd3, 8'h05});
		push_instr({OP_SW, 4'd4, 8'hFE});
		push_instr({OP_LW, 4'd7, 8'h05});
		push_instr({OP_LW, 4'd8, 8'hFE});
		drain_queue();
		read_reg(4'd7, value);
		compare_word("r7", value, 16'hBEEF);
		read_reg(4'd8, value);
		compare_word("r8", value, 16'h1357);
		report_test("memory round trip", errors_before);

		errors_before = errors;
		load_reg(4'd9, 16'h0100);
		drain_queue();
		apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
		count_before = rdata[31:16];
		for (int i = 0; i < 12; i++) begin
			push_instr({OP_INC, 4'd9, 4'd9, 4'd3});
		end
		drain_queue();
		apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
		compare_word("retired_count", rdata[31:16], count_before + 16'd12);
		read_reg(4'd9, value);
		compare_word("r9", value, 16'h0124);  // 12 steps of +3
		report_test("instruction burst", errors_before);

		errors_before = errors;
		load_reg(4'd1, 16'h5A5A);
		drain_queue();
		apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
		compare_word("error_flag", rdata[5], 1'b0);
		compare_word("pslverr", err, 1'b0);
		count_before = rdata[31:16];
		for (int op = 12; op < 16; op++) begin
			push_instr({4'(op), 4'd1, 4'd1, 4'd1});
		end
		drain_queue();
		apb_xfer(1'b0, ADDR_STATUS, '0, rdata, err);
		compare_word("error_flag", rdata[5], 1'b1);
		compare_word("retired_count", rdata[31:16], count_before + 16'd4);  // Illegal words retire
		read_reg(4'd1, value);
		compare_word("r1", value, 16'h5A5A);
		apb_xfer(1'b0, 4'h2, '0, rdata, err);
		compare_word("pslverr", err, 1'b1);
		report_test("error handling", errors_before);

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
